/* design/pmp_checker.sv */
// --------------------------------------------------
// PMP check for page table reads
// supervisor-mode read check of the walker pointer
// against four TOR regions, lowest match decides
// --------------------------------------------------
`timescale 1ns/100ps

module pmp_checker (
    input  sv32_pkg::paddr_t                                paddr_i,
    input  sv32_pkg::paddr_t [ptw_pkg::NUM_PMP_REGIONS-1:0] pmp_addr_i,
    input  logic [ptw_pkg::NUM_PMP_REGIONS-1:0]             pmp_read_i,
    output logic                                            allow_o
);
    import sv32_pkg::*;
    import ptw_pkg::*;

    logic [NUM_PMP_REGIONS-1:0] match;

    // --------------------------------------------------
    // TOR range match per region
    // --------------------------------------------------
    for (genvar k = 0; k < NUM_PMP_REGIONS; k++) begin : g_region
        paddr_t base;

        // region k starts where region k-1 ends
        if (k == 0) begin : g_first
            assign base = '0;
        end else begin : g_next
            assign base = pmp_addr_i[k-1];
        end

        // top of range is exclusive
        assign match[k] = (paddr_i >= base) && (paddr_i < pmp_addr_i[k]);
    end

    // --------------------------------------------------
    // priority select
    // --------------------------------------------------
    always_comb begin
        // no match means deny in S-mode
        allow_o = 1'b0;
        // walk downwards so the lowest numbered match wins
        for (int k = NUM_PMP_REGIONS - 1; k >= 0; k--) begin
            if (match[k]) begin
                allow_o = pmp_read_i[k];
            end
        end
    end

endmodule

/* design/pte_checker.sv */
// --------------------------------------------------
// page table entry checker
// decides whether a fetched sv32 entry is a pointer,
// a usable leaf, or a page fault
// --------------------------------------------------
`timescale 1ns/100ps

module pte_checker (
    input  sv32_pkg::pte_t        pte_i,
    input  ptw_pkg::walk_level_e  level_i,
    input  logic                  is_instr_i,
    input  logic                  is_store_i,
    input  logic                  mxr_i,
    output ptw_pkg::pte_verdict_e verdict_o
);
    import sv32_pkg::*;
    import ptw_pkg::*;

    logic pte_v;
    logic pte_r;
    logic pte_w;
    logic pte_x;
    logic pte_a;
    logic pte_d;
    logic misaligned;
    logic leaf_ok;

    // flag decode
    assign pte_v = pte_i[PTE_V];
    assign pte_r = pte_i[PTE_R];
    assign pte_w = pte_i[PTE_W_BIT];
    assign pte_x = pte_i[PTE_X];
    assign pte_a = pte_i[PTE_A];
    assign pte_d = pte_i[PTE_D];

    // 4M leaf needs the low ppn bits cleared
    assign misaligned = (level_i == LVL1) &&
                        (pte_i[PTE_PPN_LSB +: SUPERPAGE_ALIGN_W] != '0);

    // --------------------------------------------------
    // leaf permissions
    // --------------------------------------------------
    always_comb begin
        if (is_instr_i) begin
            // fetch needs execute and accessed
            leaf_ok = pte_x && pte_a;
        end else begin
            // load needs read, or execute when mxr is set
            leaf_ok = pte_a && (pte_r || (pte_x && mxr_i));
            // store also needs write and dirty, software manages d
            if (is_store_i && (!pte_w || !pte_d)) begin
                leaf_ok = 1'b0;
            end
        end
        if (misaligned) begin
            leaf_ok = 1'b0;
        end
    end

    // --------------------------------------------------
    // verdict
    // --------------------------------------------------
    always_comb begin
        if (!pte_v || (!pte_r && pte_w)) begin
            // invalid or reserved w-without-r encoding
            verdict_o = PTE_FAULT;
        end else if (!pte_r && !pte_x) begin
            // pointer, only legal from the first level
            verdict_o = (level_i == LVL1) ? PTE_POINTER : PTE_FAULT;
        end else begin
            verdict_o = leaf_ok ? PTE_LEAF_OK : PTE_FAULT;
        end
    end

    // verdict must resolve for any entry the walker holds
    always_comb begin
        assert (!$isunknown(verdict_o));
    end

endmodule

/* design/ptw_pkg.sv */
// --------------------------------------------------
// page table walker types
// walk FSM states, table levels, the verdict of the
// entry check and the PMP region count
// --------------------------------------------------

package ptw_pkg;

    // address space identifier
    localparam int ASID_W = 9;

    // TOR regions checked for page table reads
    localparam int NUM_PMP_REGIONS = 4;

    typedef logic [ASID_W-1:0] asid_t;

    // walk FSM
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR,
        PROPAGATE_ACCESS_ERROR,
        LATENCY
    } walk_state_e;

    // sv32 has two table levels, LVL1 maps 4M pages
    typedef enum logic {
        LVL1,
        LVL2
    } walk_level_e;

    // outcome of the check on one fetched entry
    typedef enum logic [1:0] {
        PTE_POINTER,
        PTE_LEAF_OK,
        PTE_FAULT
    } pte_verdict_e;

endpackage

/* design/ptw_sv32.sv */
// --------------------------------------------------
// sv32 page table walker top
// walk controller with its entry and PMP checkers
// --------------------------------------------------
`timescale 1ns/100ps

module ptw_sv32 (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // miss from the TLB
    input  logic                   tlb_miss_i,
    input  sv32_pkg::vaddr_t       miss_vaddr_i,
    input  logic                   itlb_req_i,
    input  logic                   lsu_is_store_i,
    input  ptw_pkg::asid_t         asid_i,
    input  sv32_pkg::ppn_t         satp_ppn_i,
    input  logic                   mxr_i,
    // memory port
    output logic                   mem_req_o,
    output sv32_pkg::paddr_t       mem_paddr_o,
    input  logic                   mem_gnt_i,
    input  logic                   mem_rvalid_i,
    input  sv32_pkg::pte_t         mem_rdata_i,
    // PMP setup, static during a walk
    input  sv32_pkg::paddr_t [ptw_pkg::NUM_PMP_REGIONS-1:0] pmp_addr_i,
    input  logic [ptw_pkg::NUM_PMP_REGIONS-1:0]             pmp_read_i,
    // status and results
    output logic                   ptw_active_o,
    output logic                   walking_instr_o,
    output logic                   tlb_update_valid_o,
    output logic [2*sv32_pkg::VPN_W-1:0] update_vpn_o,
    output logic                   update_is_4m_o,
    output ptw_pkg::asid_t         update_asid_o,
    output sv32_pkg::pte_t         update_pte_o,
    output logic                   ptw_error_o,
    output logic                   ptw_access_exception_o,
    output sv32_pkg::paddr_t       bad_paddr_o
);
    import sv32_pkg::*;
    import ptw_pkg::*;

    pte_t         pte;
    walk_level_e  level;
    paddr_t       pptr;
    pte_verdict_e pte_verdict;
    logic         pmp_allow;

    walk_fsm u_walk_fsm (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .tlb_miss_i             (tlb_miss_i),
        .miss_vaddr_i           (miss_vaddr_i),
        .itlb_req_i             (itlb_req_i),
        .asid_i                 (asid_i),
        .satp_ppn_i             (satp_ppn_i),
        .mem_req_o              (mem_req_o),
        .mem_paddr_o            (mem_paddr_o),
        .mem_gnt_i              (mem_gnt_i),
        .mem_rvalid_i           (mem_rvalid_i),
        .mem_rdata_i            (mem_rdata_i),
        .pte_verdict_i          (pte_verdict),
        .pmp_allow_i            (pmp_allow),
        .pte_o                  (pte),
        .level_o                (level),
        .pptr_o                 (pptr),
        .ptw_active_o           (ptw_active_o),
        .walking_instr_o        (walking_instr_o),
        .tlb_update_valid_o     (tlb_update_valid_o),
        .update_vpn_o           (update_vpn_o),
        .update_is_4m_o         (update_is_4m_o),
        .update_asid_o          (update_asid_o),
        .update_pte_o           (update_pte_o),
        .ptw_error_o            (ptw_error_o),
        .ptw_access_exception_o (ptw_access_exception_o),
        .bad_paddr_o            (bad_paddr_o)
    );

    // access type follows the walk kind and the live LSU flags
    pte_checker u_pte_checker (
        .pte_i      (pte),
        .level_i    (level),
        .is_instr_i (walking_instr_o),
        .is_store_i (lsu_is_store_i),
        .mxr_i      (mxr_i),
        .verdict_o  (pte_verdict)
    );

    // table reads are checked as S-mode loads
    pmp_checker u_pmp_checker (
        .paddr_i    (pptr),
        .pmp_addr_i (pmp_addr_i),
        .pmp_read_i (pmp_read_i),
        .allow_o    (pmp_allow)
    );

endmodule

/* design/sv32_pkg.sv */
// --------------------------------------------------
// sv32 address and page table entry layout
// widths of virtual and physical addresses, page
// numbers and the bit positions inside a PTE
// --------------------------------------------------

package sv32_pkg;

    // address widths
    localparam int VLEN          = 32;
    localparam int PLEN          = 34;
    localparam int PPN_W         = 22;
    localparam int VPN_W         = 10;
    localparam int PAGE_OFFSET_W = 12;

    // one entry is a single 32 bit word
    localparam int PTE_W = 32;

    // flag bits, in ascending order from bit 0
    localparam int PTE_V     = 0;
    localparam int PTE_R     = PTE_V + 1;
    localparam int PTE_W_BIT = PTE_R + 1;
    localparam int PTE_X     = PTE_W_BIT + 1;
    localparam int PTE_U     = PTE_X + 1;
    localparam int PTE_G     = PTE_U + 1;
    localparam int PTE_A     = PTE_G + 1;
    localparam int PTE_D     = PTE_A + 1;

    // two rsw bits sit between the flags and the ppn
    localparam int PTE_PPN_LSB = PTE_D + 3;

    // a 4M leaf must have ppn[0] cleared, which is the low 10 bits
    localparam int SUPERPAGE_ALIGN_W = 10;

    typedef logic [PTE_W-1:0] pte_t;
    typedef logic [PPN_W-1:0] ppn_t;
    typedef logic [PLEN-1:0]  paddr_t;
    typedef logic [VLEN-1:0]  vaddr_t;

endpackage

/* design/walk_fsm.sv */
// --------------------------------------------------
// sv32 walk controller
// holds pointer, level, asid and the fetched entry,
// runs the request/grant/rvalid read port and issues
// the TLB update or the fault and exception pulses
// --------------------------------------------------
`timescale 1ns/100ps

module walk_fsm (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // walk start
    input  logic                  tlb_miss_i,
    input  sv32_pkg::vaddr_t      miss_vaddr_i,
    input  logic                  itlb_req_i,
    input  ptw_pkg::asid_t        asid_i,
    input  sv32_pkg::ppn_t        satp_ppn_i,
    // memory port
    output logic                  mem_req_o,
    output sv32_pkg::paddr_t      mem_paddr_o,
    input  logic                  mem_gnt_i,
    input  logic                  mem_rvalid_i,
    input  sv32_pkg::pte_t        mem_rdata_i,
    // checker verdicts
    input  ptw_pkg::pte_verdict_e pte_verdict_i,
    input  logic                  pmp_allow_i,
    output sv32_pkg::pte_t        pte_o,
    output ptw_pkg::walk_level_e  level_o,
    output sv32_pkg::paddr_t      pptr_o,
    // results
    output logic                  ptw_active_o,
    output logic                  walking_instr_o,
    output logic                  tlb_update_valid_o,
    output logic [2*sv32_pkg::VPN_W-1:0] update_vpn_o,
    output logic                  update_is_4m_o,
    output ptw_pkg::asid_t        update_asid_o,
    output sv32_pkg::pte_t        update_pte_o,
    output logic                  ptw_error_o,
    output logic                  ptw_access_exception_o,
    output sv32_pkg::paddr_t      bad_paddr_o
);
    import sv32_pkg::*;
    import ptw_pkg::*;

    walk_state_e state_q, state_d;
    walk_level_e level_q, level_d;
    paddr_t      pptr_q, pptr_d;
    vaddr_t      vaddr_q, vaddr_d;
    asid_t       asid_q, asid_d;
    logic        is_instr_q, is_instr_d;
    logic        global_q, global_d;
    // read port registered before use
    pte_t        pte_q;
    logic        rvalid_q;

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign ptw_active_o    = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;
    assign mem_req_o       = (state_q == WAIT_GRANT);
    assign mem_paddr_o     = pptr_q;
    assign pte_o           = pte_q;
    assign level_o         = level_q;
    assign pptr_o          = pptr_q;

    assign update_vpn_o   = vaddr_q[VLEN-1:PAGE_OFFSET_W];
    assign update_is_4m_o = (level_q == LVL1);
    assign update_asid_o  = asid_q;
    // global from a level-1 pointer carries into the leaf
    assign update_pte_o   = pte_q | (pte_t'(global_q) << PTE_G);

    // failed pointer only shown with the exception pulse
    assign bad_paddr_o = ptw_access_exception_o ? pptr_q : '0;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_d                = state_q;
        level_d                = level_q;
        pptr_d                 = pptr_q;
        vaddr_d                = vaddr_q;
        asid_d                 = asid_q;
        is_instr_d             = is_instr_q;
        global_d               = global_q;
        tlb_update_valid_o     = 1'b0;
        ptw_error_o            = 1'b0;
        ptw_access_exception_o = 1'b0;

        case (state_q)
            IDLE: begin
                // every walk starts at the root table
                level_d    = LVL1;
                global_d   = 1'b0;
                is_instr_d = 1'b0;
                if (tlb_miss_i) begin
                    // root pointer is satp.ppn * 4K + vpn[1] * 4
                    pptr_d     = {satp_ppn_i, miss_vaddr_i[VLEN-1 -: VPN_W], 2'b00};
                    vaddr_d    = miss_vaddr_i;
                    asid_d     = asid_i;
                    is_instr_d = itlb_req_i;
                    state_d    = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                // request and address held until granted
                if (mem_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    if (pte_q[PTE_G]) begin
                        global_d = 1'b1;
                    end
                    // PMP denial wins over any entry verdict
                    // pointer stays put for bad_paddr
                    if (!pmp_allow_i) begin
                        state_d = PROPAGATE_ACCESS_ERROR;
                    end else begin
                        case (pte_verdict_i)
                            PTE_LEAF_OK: begin
                                tlb_update_valid_o = 1'b1;
                                state_d            = LATENCY;
                            end
                            PTE_POINTER: begin
                                // next table: pte.ppn * 4K + vpn[0] * 4
                                level_d = LVL2;
                                pptr_d  = {pte_q[PTE_PPN_LSB +: PPN_W],
                                           vaddr_q[VLEN-VPN_W-1:PAGE_OFFSET_W], 2'b00};
                                state_d = WAIT_GRANT;
                            end
                            default: state_d = PROPAGATE_ERROR;
                        endcase
                    end
                end
            end
            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = LATENCY;
            end
            PROPAGATE_ACCESS_ERROR: begin
                ptw_access_exception_o = 1'b1;
                state_d                = LATENCY;
            end
            LATENCY: begin
                state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            level_q    <= LVL1;
            pptr_q     <= '0;
            vaddr_q    <= '0;
            asid_q     <= '0;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
            pte_q      <= '0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            level_q    <= level_d;
            pptr_q     <= pptr_d;
            vaddr_q    <= vaddr_d;
            asid_q     <= asid_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
            pte_q      <= mem_rdata_i;
            rvalid_q   <= mem_rvalid_i;
        end
    end

    // read data only returns while the walker waits for it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> state_q == PTE_LOOKUP);

    // update, fault and access exception never overlap
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({tlb_update_valid_o, ptw_error_o, ptw_access_exception_o}));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sv32 walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_ptw_sv32 \
    -Mdir obj_dir \
    -o sim_ptw

./obj_dir/sim_ptw | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* testbench/tb_page_memory.sv */
// --------------------------------------------------
// page table memory model
// word memory with a preloaded sv32 table, grants
// after a pseudo-random delay, read data one cycle
// after the grant
// --------------------------------------------------
`timescale 1ns/100ps

module tb_page_memory (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             req_i,
    input  sv32_pkg::paddr_t addr_i,
    output logic             gnt_o,
    output logic             rvalid_o,
    output sv32_pkg::pte_t   rdata_o
);
    import sv32_pkg::*;

    // sparse store, unmapped words read as invalid entries
    pte_t        mem [paddr_t];
    logic [31:0] lcg_q;
    logic [1:0]  wait_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------------------------------------
    // root table at 0x80000, second table at 0x81000
    // --------------------------------------------------
    initial begin
        mem[34'h0_0008_0004] = 32'h0002_0421;  // vpn1=1 pointer to 0x81, global
        mem[34'h0_0008_0008] = 32'h0030_0049;  // vpn1=2 4M leaf, x a
        mem[34'h0_0008_0010] = 32'h0040_0043;  // vpn1=4 4M leaf, r a, no x
        mem[34'h0_0008_0014] = 32'h0040_0443;  // vpn1=5 4M leaf, ppn not aligned
        mem[34'h0_0008_0018] = 32'h0004_0001;  // vpn1=6 pointer into unreadable region
        mem[34'h0_0008_1004] = 32'h048D_1443;  // vpn0=1 leaf, r a
        mem[34'h0_0008_1008] = 32'h0888_8847;  // vpn0=2 leaf, r w a, d clear
        mem[34'h0_0008_100C] = 32'h0002_0401;  // vpn0=3 pointer at level 2
        mem[34'h0_0008_1010] = 32'h0CCC_CC49;  // vpn0=4 execute-only leaf
    end

    // grant once the wait count has run out
    assign gnt_o = req_i && (wait_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lcg_q    <= 32'hd068;
            wait_q   <= 2'd1;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
        end else begin
            rvalid_o <= gnt_o;
            if (gnt_o) begin
                rdata_o <= mem.exists(addr_i) ? mem[addr_i] : '0;
                // next request waits 0 to 3 cycles
                lcg_q   <= lcg_next(lcg_q);
                wait_q  <= lcg_q[17:16];
            end else if (req_i && (wait_q != '0)) begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

/* testbench/tb_ptw_sv32.sv */
// --------------------------------------------------
// sv32 page table walker testbench
// runs a table of misses against a preloaded page
// table and checks the update, fault or exception
// --------------------------------------------------
`timescale 1ns/100ps

module tb_ptw_sv32;
    import sv32_pkg::*;
    import ptw_pkg::*;

    typedef enum logic [1:0] {RES_NONE, RES_UPDATE, RES_FAULT, RES_ACCESS} result_e;

    typedef struct packed {
        vaddr_t  vaddr;
        logic    instr;
        logic    store;
        logic    mxr;
        asid_t   asid;
        result_e result;
        logic    is_4m;
        pte_t    pte;
        paddr_t  bad_paddr;
    } row_t;

    localparam int   NUM_ROWS   = 10;
    localparam int   MAX_CYCLES = NUM_ROWS * 64;
    localparam ppn_t ROOT_PPN   = 22'h00080;

    // names follow the DUT ports
    logic                          clk_i = 1'b0;
    logic                          rst_ni;
    logic                          tlb_miss_i;
    vaddr_t                        miss_vaddr_i;
    logic                          itlb_req_i;
    logic                          lsu_is_store_i;
    asid_t                         asid_i;
    ppn_t                          satp_ppn_i;
    logic                          mxr_i;
    logic                          mem_req_o;
    paddr_t                        mem_paddr_o;
    logic                          mem_gnt_i;
    logic                          mem_rvalid_i;
    pte_t                          mem_rdata_i;
    paddr_t [NUM_PMP_REGIONS-1:0]  pmp_addr_i;
    logic [NUM_PMP_REGIONS-1:0]    pmp_read_i;
    logic                          ptw_active_o;
    logic                          walking_instr_o;
    logic                          tlb_update_valid_o;
    logic [2*VPN_W-1:0]            update_vpn_o;
    logic                          update_is_4m_o;
    asid_t                         update_asid_o;
    pte_t                          update_pte_o;
    logic                          ptw_error_o;
    logic                          ptw_access_exception_o;
    paddr_t                        bad_paddr_o;

    row_t rows [NUM_ROWS];
    int   cycle_cnt = 0;
    int   pulse_cnt = 0;

    ptw_sv32 uut (.*);

    tb_page_memory u_mem (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (mem_req_o),
        .addr_i   (mem_paddr_o),
        .gnt_o    (mem_gnt_i),
        .rvalid_o (mem_rvalid_i),
        .rdata_o  (mem_rdata_i)
    );

    always #5 clk_i = ~clk_i;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // entry layout is ppn, two rsw bits and the flag byte
    function automatic pte_t pte_word(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // next table address is ppn * 4K + vpn * 4
    function automatic paddr_t table_pointer(input ppn_t ppn, input logic [VPN_W-1:0] vpn);
        return {ppn, vpn, 2'b00};
    endfunction

    function automatic result_e observed_result();
        if (tlb_update_valid_o) return RES_UPDATE;
        if (ptw_error_o) return RES_FAULT;
        if (ptw_access_exception_o) return RES_ACCESS;
        return RES_NONE;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_update(input logic [2*VPN_W-1:0] vpn, input logic is_4m,
                                input asid_t asid, input pte_t pte);
        if (update_vpn_o !== vpn || update_is_4m_o !== is_4m) begin
            abort_run($sformatf("[FAIL] %0t: update vpn %h 4m %b expected %h %b",
                                $time, update_vpn_o, update_is_4m_o, vpn, is_4m));
        end
        if (update_asid_o !== asid || update_pte_o !== pte) begin
            abort_run($sformatf("[FAIL] %0t: update asid %h pte %h expected %h %h",
                                $time, update_asid_o, update_pte_o, asid, pte));
        end
    endtask

    task automatic check_fault(input result_e exp, input result_e got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: result %s expected %s",
                                $time, got.name(), exp.name()));
        end
    endtask

    task automatic check_paddr(input string name, input paddr_t exp, input paddr_t got);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s %h expected %h", $time, name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // watchdog and result pulse count
    // --------------------------------------------------
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run("timeout: the walker did not finish all misses within the cycle limit");
        end
    end

    always @(posedge clk_i) begin
        if (observed_result() != RES_NONE) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        row_t    row;
        result_e got;
        int      start_pulses;

        // vaddr, instr, store, mxr, asid, result, 4m, pte, bad address
        rows[0] = '{32'h0040_1234, 1'b0, 1'b0, 1'b0, 9'h011, RES_UPDATE, 1'b0,
                    pte_word(22'h12345, 8'h63), '0};
        rows[1] = '{32'h0080_0ABC, 1'b1, 1'b0, 1'b0, 9'h022, RES_UPDATE, 1'b1,
                    pte_word(22'h00C00, 8'h49), '0};
        // invalid, no x, d clear, misaligned 4M, level-2 pointer
        rows[2] = '{32'h00C0_0000, 1'b0, 1'b0, 1'b0, 9'h033, RES_FAULT, 1'b0, '0, '0};
        rows[3] = '{32'h0100_0000, 1'b1, 1'b0, 1'b0, 9'h044, RES_FAULT, 1'b0, '0, '0};
        rows[4] = '{32'h0040_2000, 1'b0, 1'b1, 1'b0, 9'h055, RES_FAULT, 1'b0, '0, '0};
        rows[5] = '{32'h0140_0000, 1'b0, 1'b0, 1'b0, 9'h066, RES_FAULT, 1'b0, '0, '0};
        rows[6] = '{32'h0040_3000, 1'b0, 1'b0, 1'b0, 9'h077, RES_FAULT, 1'b0, '0, '0};
        // execute-only leaf where a load faults unless mxr is set
        rows[7] = '{32'h0040_4000, 1'b0, 1'b0, 1'b0, 9'h088, RES_FAULT, 1'b0, '0, '0};
        rows[8] = '{32'h0040_4000, 1'b0, 1'b0, 1'b1, 9'h099, RES_UPDATE, 1'b0,
                    pte_word(22'h33333, 8'h69), '0};
        rows[9] = '{32'h0180_0000, 1'b0, 1'b0, 1'b0, 9'h1AA, RES_ACCESS, 1'b0, '0,
                    table_pointer(22'h00100, 10'h000)};

        rst_ni         = 1'b0;
        tlb_miss_i     = 1'b0;
        miss_vaddr_i   = '0;
        itlb_req_i     = 1'b0;
        lsu_is_store_i = 1'b0;
        asid_i         = '0;
        satp_ppn_i     = ROOT_PPN;
        mxr_i          = 1'b0;
        // tables readable apart from one page at 0x100000
        pmp_addr_i[0]  = 34'h0_0010_0000;
        pmp_addr_i[1]  = 34'h0_0010_1000;
        pmp_addr_i[2]  = 34'h0_0040_0000;
        pmp_addr_i[3]  = 34'h0_0040_0000;
        pmp_read_i     = 4'b0101;

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = rows[i];
            @(negedge clk_i);
            start_pulses   = pulse_cnt;
            tlb_miss_i     = 1'b1;
            miss_vaddr_i   = row.vaddr;
            itlb_req_i     = row.instr;
            lsu_is_store_i = row.store;
            asid_i         = row.asid;
            mxr_i          = row.mxr;
            @(negedge clk_i);
            check_flag("ptw_active_o", 1'b1, ptw_active_o);
            check_flag("mem_req_o", 1'b1, mem_req_o);
            // first read goes to the root table entry of vpn[1]
            check_paddr("mem_paddr_o", table_pointer(ROOT_PPN, row.vaddr[VLEN-1 -: VPN_W]),
                        mem_paddr_o);
            // strobe stays high with other values while busy
            // the walker must ignore it
            miss_vaddr_i = ~row.vaddr;
            asid_i       = ~row.asid;
            @(negedge clk_i);
            tlb_miss_i = 1'b0;
            while (observed_result() == RES_NONE) begin
                check_flag("walking_instr_o", row.instr, walking_instr_o);
                @(negedge clk_i);
            end
            got = observed_result();
            check_fault(row.result, got);
            if (got == RES_UPDATE) begin
                check_update(row.vaddr[VLEN-1:PAGE_OFFSET_W], row.is_4m, row.asid, row.pte);
            end
            if (got == RES_ACCESS) begin
                check_paddr("bad_paddr_o", row.bad_paddr, bad_paddr_o);
            end
            while (ptw_active_o) begin
                @(negedge clk_i);
            end
            if (pulse_cnt - start_pulses != 1) begin
                abort_run($sformatf("[FAIL] %0t: row %0d gave %0d result pulses",
                                    $time, i, pulse_cnt - start_pulses));
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* vlog.f */
design/sv32_pkg.sv
design/ptw_pkg.sv
design/pte_checker.sv
design/pmp_checker.sv
design/walk_fsm.sv
design/ptw_sv32.sv
testbench/tb_page_memory.sv
testbench/tb_ptw_sv32.sv
